//--- rtl/mul_pkg.sv
package mul_pkg;

    // ##############################
    // Multiplier widths
    // ##############################

    localparam int unsigned op_w = 16;
    localparam int unsigned prod_w = 2 * op_w;

    // First partial-product row that is summed exactly
    localparam int unsigned exact_row = 6;

    // Width of the sparse correction words
    localparam int unsigned corr_w = 21;

    // ##############################
    // Accumulation
    // ##############################

    // 8 bits of headroom, good for 256 products
    localparam int unsigned acc_w = prod_w + 8;
    localparam int unsigned ext_w = acc_w - prod_w;

    localparam int unsigned lanes = 4;

    // Two extra bits cover the four-lane sum
    localparam int unsigned sum_w = acc_w + $clog2(lanes);

endpackage

//--- rtl/ctrl_pkg.sv
package ctrl_pkg;

    // One select bit per power of two lanes
    localparam int unsigned lane_sel_w = $clog2(mul_pkg::lanes);

    // Opcode stream seen by the dispatcher
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_LOAD  = 2'd1,
        OP_CLEAR = 2'd2,
        OP_READ  = 2'd3
    } op_e;

    // Reducer FSM
    typedef enum logic {
        RED_IDLE = 1'b0,
        RED_SUM  = 1'b1
    } red_state_e;

endpackage

//--- rtl/approx_mul_16.sv
`timescale 1ns/1ns

module approx_mul_16 (
    input  logic signed [mul_pkg::op_w-1:0]   x,
    input  logic signed [mul_pkg::op_w-1:0]   y,
    output logic        [mul_pkg::prod_w-1:0] z
);

    // Unshifted partial-product rows, one per bit of x
    logic [mul_pkg::op_w-1:0] pp [mul_pkg::op_w];

    // Sparse words that stand in for rows 0 to 5
    logic [mul_pkg::corr_w-1:0] c0;
    logic [mul_pkg::corr_w-1:0] c1;
    logic [mul_pkg::corr_w-1:0] c2;
    logic [mul_pkg::corr_w-1:0] c3;

    logic [mul_pkg::prod_w-1:0] exact_sum;

    // ##############################
    // Baugh-Wooley rows
    // ##############################

    // Rows 0 to 14 invert the sign column
    for (genvar r = 0; r < mul_pkg::op_w - 1; r++) begin : g_row
        assign pp[r] = {~(y[15] & x[r]), y[14:0] & {15{x[r]}}};
    end

    // Last row inverts the body instead
    assign pp[15] = {y[15] & x[15], ~(y[14:0] & {15{x[15]}})};

    // ##############################
    // Correction words, rows 0 to 5
    // ##############################

    always_comb begin
        c0 = '0;
        c0[4]  = pp[4][0];
        c0[6]  = pp[0][6] | pp[1][5];
        c0[9]  = pp[0][8] & pp[1][7];
        c0[10] = pp[0][10] ^ pp[1][9];
        c0[12] = pp[2][10] ^ pp[3][9];
        c0[13] = pp[2][10] & pp[3][9];
        c0[15] = pp[0][15] ^ pp[1][14];
        c0[16] = pp[2][13] | pp[3][12];
        c0[17] = pp[2][15] | pp[3][14];
        c0[18] = pp[2][15] & pp[3][14];
        c0[19] = pp[4][14] & pp[5][13];
        c0[20] = pp[4][15] & pp[5][14];
    end

    always_comb begin
        c1 = '0;
        c1[6]  = pp[0][6] ^ pp[1][5];
        c1[9]  = pp[2][6] & pp[3][5];
        c1[10] = pp[2][7] & pp[3][6];
        c1[12] = pp[4][7] & pp[5][6];
        c1[15] = pp[2][12] & pp[3][11];
        c1[16] = pp[4][12] | pp[5][11];
        c1[17] = pp[2][15] ^ pp[3][14];
        // Sign columns of rows 3 and 5 pass straight through
        c1[18] = pp[3][15];
        c1[19] = pp[4][15] ^ pp[5][14];
        c1[20] = pp[5][15];
    end

    always_comb begin
        c2 = '0;
        c2[15] = pp[2][12] | pp[3][11];
        c2[17] = pp[4][13] ^ pp[5][12];
        c2[18] = pp[4][14] ^ pp[5][13];
    end

    always_comb begin
        c3 = '0;
        c3[15] = pp[4][11] ^ pp[5][10];
    end

    // ##############################
    // Rows 6 to 15, exact
    // ##############################

    always_comb begin
        exact_sum = '0;
        // Each row is widened to the product width before its shift
        for (int i = mul_pkg::exact_row; i < mul_pkg::op_w; i++) begin
            exact_sum = exact_sum + (pp[i] << i);
        end
        // Constant one above the last row
        exact_sum = exact_sum + {1'b1, {(mul_pkg::prod_w - 1){1'b0}}};
    end

    assign z = exact_sum + c0 + c1 + c2 + c3;

endmodule

//--- rtl/mac_lane.sv
`timescale 1ns/1ns

module mac_lane (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             en,
    input  logic                             clr,
    input  logic signed [mul_pkg::op_w-1:0]  x,
    input  logic signed [mul_pkg::op_w-1:0]  y,
    output logic signed [mul_pkg::acc_w-1:0] acc
);

    logic        [mul_pkg::prod_w-1:0] prod;
    logic signed [mul_pkg::acc_w-1:0]  prod_ext;

    approx_mul_16 u_mul (
        .x (x),
        .y (y),
        .z (prod)
    );

    // Product is two's complement, widen by its top bit
    assign prod_ext = {{(mul_pkg::ext_w){prod[mul_pkg::prod_w-1]}}, prod};

    // Clear wins over a strobe in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (clr) begin
            acc <= '0;
        end else if (en) begin
            acc <= acc + prod_ext;
        end
    end

endmodule

//--- rtl/op_dispatch.sv
`timescale 1ns/1ns

module op_dispatch (
    input  logic                                clk,
    input  logic                                rst_n,
    input  ctrl_pkg::op_e                       op,
    input  logic [ctrl_pkg::lane_sel_w-1:0]     lane_sel,
    input  logic signed [mul_pkg::op_w-1:0]     x,
    input  logic signed [mul_pkg::op_w-1:0]     y,
    input  logic                                busy,
    output logic [mul_pkg::lanes-1:0]           lane_en,
    output logic                                clr,
    output logic                                start,
    output logic signed [mul_pkg::op_w-1:0]     x_q,
    output logic signed [mul_pkg::op_w-1:0]     y_q
);

    logic load_ok;

    assign load_ok = (op == ctrl_pkg::OP_LOAD) && !busy;

    // ##############################
    // Opcode decode
    // ##############################

    // Nothing is decoded while a reduction walks the lanes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_en <= '0;
            clr     <= 1'b0;
            start   <= 1'b0;
        end else begin
            lane_en <= '0;
            clr     <= 1'b0;
            start   <= 1'b0;
            if (!busy) begin
                case (op)
                    ctrl_pkg::OP_NOP:   ;
                    ctrl_pkg::OP_LOAD:  lane_en[lane_sel] <= 1'b1;
                    ctrl_pkg::OP_CLEAR: clr <= 1'b1;
                    ctrl_pkg::OP_READ:  start <= 1'b1;
                    default:            ;
                endcase
            end
        end
    end

    // Operands only move on an accepted load
    always_ff @(posedge clk) begin
        if (load_ok) begin
            x_q <= x;
            y_q <= y;
        end
    end

endmodule

//--- rtl/acc_reduce.sv
`timescale 1ns/1ns

module acc_reduce (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic signed [mul_pkg::acc_w-1:0] acc [mul_pkg::lanes],
    output logic                             busy,
    output logic                             sum_valid,
    output logic signed [mul_pkg::sum_w-1:0] sum
);

    ctrl_pkg::red_state_e                state;
    logic [ctrl_pkg::lane_sel_w-1:0]     idx;
    logic signed [mul_pkg::sum_w-1:0]    total;
    logic                                last_lane;

    assign last_lane = (idx == ctrl_pkg::lane_sel_w'(mul_pkg::lanes - 1));

    // Covers the start cycle, the walk and the result cycle
    assign busy = start || (state == ctrl_pkg::RED_SUM) || sum_valid;

    // ##############################
    // Lane walk
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ctrl_pkg::RED_IDLE;
            idx       <= '0;
            sum_valid <= 1'b0;
            sum       <= '0;
        end else begin
            sum_valid <= 1'b0;
            case (state)
                ctrl_pkg::RED_IDLE: begin
                    if (start) begin
                        // Lane 0 is taken on the way in
                        state <= ctrl_pkg::RED_SUM;
                        idx   <= ctrl_pkg::lane_sel_w'(1);
                    end
                end
                ctrl_pkg::RED_SUM: begin
                    if (last_lane) begin
                        state     <= ctrl_pkg::RED_IDLE;
                        idx       <= '0;
                        sum       <= total + acc[idx];
                        sum_valid <= 1'b1;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                default: state <= ctrl_pkg::RED_IDLE;
            endcase
        end
    end

    // Running total restarts from lane 0
    always_ff @(posedge clk) begin
        if (state == ctrl_pkg::RED_IDLE && start) begin
            total <= mul_pkg::sum_w'(acc[0]);
        end else if (state == ctrl_pkg::RED_SUM && !last_lane) begin
            total <= total + acc[idx];
        end
    end

endmodule

//--- rtl/dot_engine_top.sv
`timescale 1ns/1ns

module dot_engine_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  ctrl_pkg::op_e                       op,
    input  logic [ctrl_pkg::lane_sel_w-1:0]     lane_sel,
    input  logic signed [mul_pkg::op_w-1:0]     x,
    input  logic signed [mul_pkg::op_w-1:0]     y,
    output logic                                busy,
    output logic                                sum_valid,
    output logic signed [mul_pkg::sum_w-1:0]    sum
);

    logic [mul_pkg::lanes-1:0]           lane_en;
    logic                                clr;
    logic                                start;
    logic signed [mul_pkg::op_w-1:0]     x_q;
    logic signed [mul_pkg::op_w-1:0]     y_q;
    logic signed [mul_pkg::acc_w-1:0]    lane_acc [mul_pkg::lanes];

    op_dispatch u_dispatch (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (op),
        .lane_sel (lane_sel),
        .x        (x),
        .y        (y),
        .busy     (busy),
        .lane_en  (lane_en),
        .clr      (clr),
        .start    (start),
        .x_q      (x_q),
        .y_q      (y_q)
    );

    // Lanes share operands and clear, each has its own strobe
    for (genvar i = 0; i < mul_pkg::lanes; i++) begin : g_lane
        mac_lane u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .en    (lane_en[i]),
            .clr   (clr),
            .x     (x_q),
            .y     (y_q),
            .acc   (lane_acc[i])
        );
    end

    acc_reduce u_reduce (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .acc       (lane_acc),
        .busy      (busy),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

endmodule

//--- test/dot_checker.sv
`timescale 1ns/1ns

module dot_checker (
    input  logic                                clk,
    input  logic                                rst_n,
    input  ctrl_pkg::op_e                       op,
    input  logic [ctrl_pkg::lane_sel_w-1:0]     lane_sel,
    input  logic signed [mul_pkg::op_w-1:0]     x,
    input  logic signed [mul_pkg::op_w-1:0]     y,
    input  logic                                busy,
    input  logic                                sum_valid,
    input  logic signed [mul_pkg::sum_w-1:0]    sum,
    input  int                                  test_id,
    output int                                  value_errs,
    output int                                  other_errs,
    output int                                  reads_checked
);

    localparam int k_pass = 0;
    localparam int k_and = 1;
    localparam int k_or = 2;
    localparam int k_xor = 3;

    // Edge after the read is sampled on which the result shows
    localparam int result_edge = 5;

    logic signed [mul_pkg::acc_w-1:0] model_acc [mul_pkg::lanes];
    logic signed [mul_pkg::sum_w-1:0] exp_sum;
    logic        [mul_pkg::prod_w-1:0] prod;
    logic                             exp_busy;
    int                               read_age;
    int                               read_test;

    function automatic string test_name(input int id);
        case (id)
            1: return "reset";
            2: return "single_product";
            3: return "random_sequence";
            4: return "clear";
            5: return "drop_while_busy";
            default: return "startup";
        endcase
    endfunction

    // ##############################
    // Multiplier model
    // ##############################

    function automatic logic pp_bit(input logic [15:0] a, input logic [15:0] b,
                                    input int r, input int c);
        logic v;
        v = a[r] & b[c];
        // Sign column of rows 0 to 14 and body of row 15 are inverted
        if ((r < 15) == (c == 15)) begin
            v = ~v;
        end
        return v;
    endfunction

    // Row r, column c paired with row r+1 in the same column of weight
    function automatic longint corr(input logic [15:0] a, input logic [15:0] b,
                                    input int kind, input int r, input int c,
                                    input int pos);
        logic hi;
        logic lo;
        logic v;
        hi = pp_bit(a, b, r, c);
        lo = 1'b0;
        if (kind != k_pass) begin
            lo = pp_bit(a, b, r + 1, c - 1);
        end
        case (kind)
            k_and:   v = hi & lo;
            k_or:    v = hi | lo;
            k_xor:   v = hi ^ lo;
            default: v = hi;
        endcase
        return longint'(v) << pos;
    endfunction

    function automatic logic [31:0] approx_product(input logic [15:0] a,
                                                   input logic [15:0] b);
        longint s;
        s = longint'(1) << 31;
        for (int r = 6; r < 16; r++) begin
            for (int c = 0; c < 16; c++) begin
                s = s + (longint'(pp_bit(a, b, r, c)) << (r + c));
            end
        end
        s = s + corr(a, b, k_pass, 4, 0, 4);
        s = s + corr(a, b, k_or, 0, 6, 6);
        s = s + corr(a, b, k_and, 0, 8, 9);
        s = s + corr(a, b, k_xor, 0, 10, 10);
        s = s + corr(a, b, k_xor, 2, 10, 12);
        s = s + corr(a, b, k_and, 2, 10, 13);
        s = s + corr(a, b, k_xor, 0, 15, 15);
        s = s + corr(a, b, k_or, 2, 13, 16);
        s = s + corr(a, b, k_or, 2, 15, 17);
        s = s + corr(a, b, k_and, 2, 15, 18);
        s = s + corr(a, b, k_and, 4, 14, 19);
        s = s + corr(a, b, k_and, 4, 15, 20);
        s = s + corr(a, b, k_xor, 0, 6, 6);
        s = s + corr(a, b, k_and, 2, 6, 9);
        s = s + corr(a, b, k_and, 2, 7, 10);
        s = s + corr(a, b, k_and, 4, 7, 12);
        s = s + corr(a, b, k_and, 2, 12, 15);
        s = s + corr(a, b, k_or, 4, 12, 16);
        s = s + corr(a, b, k_xor, 2, 15, 17);
        s = s + corr(a, b, k_pass, 3, 15, 18);
        s = s + corr(a, b, k_xor, 4, 15, 19);
        s = s + corr(a, b, k_pass, 5, 15, 20);
        s = s + corr(a, b, k_or, 2, 12, 15);
        s = s + corr(a, b, k_xor, 4, 13, 17);
        s = s + corr(a, b, k_xor, 4, 14, 18);
        s = s + corr(a, b, k_xor, 4, 11, 15);
        return s[31:0];
    endfunction

    initial begin
        value_errs = 0;
        other_errs = 0;
        reads_checked = 0;
        read_age = -1;
        read_test = 0;
    end

    // ##############################
    // Lane model and compare
    // ##############################

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mul_pkg::lanes; i++) begin
                model_acc[i] = '0;
            end
            read_age = -1;
        end else begin
            if (read_age >= 0) begin
                read_age = read_age + 1;
            end
            if (read_age > result_edge) begin
                read_age = -1;
            end
            exp_busy = (read_age >= 1);

            if (busy !== exp_busy) begin
                $display("Busy is %b at %0t but should be %b in test %s",
                         busy, $time, exp_busy, test_name(test_id));
                other_errs++;
            end

            if (read_age == result_edge) begin
                if (sum_valid !== 1'b1) begin
                    $display("sum_valid missing at %0t for the read in test %s",
                             $time, test_name(read_test));
                    other_errs++;
                end else begin
                    reads_checked++;
                    if (sum !== exp_sum) begin
                        $display("** Error [%s] at %0t: sum expected %0d, actual %0d",
                                 test_name(read_test), $time, exp_sum, sum);
                        value_errs++;
                    end
                end
            end else if (sum_valid !== 1'b0) begin
                $display("Unexpected sum_valid at %0t in test %s",
                         $time, test_name(test_id));
                other_errs++;
            end

            // Ops seen during a reduction never reach the lanes
            if (!exp_busy) begin
                case (op)
                    ctrl_pkg::OP_LOAD: begin
                        prod = approx_product(x, y);
                        model_acc[lane_sel] = model_acc[lane_sel]
                            + {{(mul_pkg::acc_w - mul_pkg::prod_w){prod[31]}}, prod};
                    end
                    ctrl_pkg::OP_CLEAR: begin
                        for (int i = 0; i < mul_pkg::lanes; i++) begin
                            model_acc[i] = '0;
                        end
                    end
                    ctrl_pkg::OP_READ: begin
                        exp_sum = '0;
                        for (int i = 0; i < mul_pkg::lanes; i++) begin
                            exp_sum = exp_sum
                                + {{(mul_pkg::sum_w - mul_pkg::acc_w){model_acc[i][39]}},
                                   model_acc[i]};
                        end
                        read_test = test_id;
                        read_age = 0;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- test/tb_dot_engine.sv
`timescale 1ns/1ns

module tb_dot_engine;

    localparam int n_single = 12;
    localparam int n_seq = 6;
    localparam int seq_len = 20;
    localparam int n_clear_loads = 8;
    localparam int n_drop = 4;
    localparam int drop_len = 5;
    localparam int n_reads = 1 + n_single + n_seq + 2 + n_drop + 1;

    // Stimulus edges outside of reads, with some slack for reset and drain
    localparam int stim_cycles = 2 * n_single + n_seq * seq_len + n_clear_loads + 1
                                 + n_drop * (2 + drop_len + 1) + 20;
    localparam int watchdog_cycles = stim_cycles + 20 * n_reads;

    logic                                clk;
    logic                                rst_n;
    ctrl_pkg::op_e                       op;
    logic [ctrl_pkg::lane_sel_w-1:0]     lane_sel;
    logic signed [mul_pkg::op_w-1:0]     x;
    logic signed [mul_pkg::op_w-1:0]     y;
    logic                                busy;
    logic                                sum_valid;
    logic signed [mul_pkg::sum_w-1:0]    sum;

    int test_id;
    int value_errs;
    int other_errs;
    int reads_checked;
    int tb_errs;

    dot_engine_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .lane_sel  (lane_sel),
        .x         (x),
        .y         (y),
        .busy      (busy),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    dot_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .op            (op),
        .lane_sel      (lane_sel),
        .x             (x),
        .y             (y),
        .busy          (busy),
        .sum_valid     (sum_valid),
        .sum           (sum),
        .test_id       (test_id),
        .value_errs    (value_errs),
        .other_errs    (other_errs),
        .reads_checked (reads_checked)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [15:0] rand_word();
        return 16'($urandom);
    endfunction

    // Operand pairs packed as {x, y}
    function automatic logic [31:0] corner_pair(input int i);
        case (i)
            0: return {16'h8000, 16'h8000};
            1: return {16'h8000, 16'h7fff};
            2: return {16'hffff, 16'hffff};
            3: return {16'hffff, 16'h8000};
            4: return {16'h7fff, 16'h8000};
            default: return {rand_word(), rand_word()};
        endcase
    endfunction

    task automatic issue(input ctrl_pkg::op_e o, input logic [ctrl_pkg::lane_sel_w-1:0] sel,
                         input logic [15:0] a, input logic [15:0] b);
        @(posedge clk);
        op       <= o;
        lane_sel <= sel;
        x        <= a;
        y        <= b;
    endtask

    task automatic load_random();
        issue(ctrl_pkg::OP_LOAD, ctrl_pkg::lane_sel_w'($urandom), rand_word(), rand_word());
    endtask

    task automatic read_sum();
        issue(ctrl_pkg::OP_READ, '0, '0, '0);
        issue(ctrl_pkg::OP_NOP, '0, '0, '0);
        while (sum_valid !== 1'b1) begin
            @(posedge clk);
        end
    endtask

    // ##############################
    // Stimulus
    // ##############################

    initial begin
        logic [31:0] pair;
        void'($urandom(32'hc501f44b));
        rst_n = 1'b0;
        op = ctrl_pkg::OP_NOP;
        lane_sel = '0;
        x = '0;
        y = '0;
        test_id = 0;
        tb_errs = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        test_id = 1;
        read_sum();

        test_id = 2;
        for (int i = 0; i < n_single; i++) begin
            pair = corner_pair(i);
            issue(ctrl_pkg::OP_CLEAR, '0, '0, '0);
            issue(ctrl_pkg::OP_LOAD, ctrl_pkg::lane_sel_w'($urandom), pair[31:16], pair[15:0]);
            read_sum();
        end

        test_id = 3;
        for (int s = 0; s < n_seq; s++) begin
            for (int k = 0; k < seq_len; k++) begin
                load_random();
            end
            read_sum();
        end

        test_id = 4;
        issue(ctrl_pkg::OP_CLEAR, '0, '0, '0);
        read_sum();
        for (int k = 0; k < n_clear_loads; k++) begin
            load_random();
        end
        read_sum();

        test_id = 5;
        for (int i = 0; i < n_drop; i++) begin
            load_random();
            load_random();
            issue(ctrl_pkg::OP_READ, '0, '0, '0);
            // Each of these is sampled while the reducer is busy
            for (int k = 0; k < drop_len; k++) begin
                issue(ctrl_pkg::op_e'(2'($urandom)), ctrl_pkg::lane_sel_w'($urandom),
                      rand_word(), rand_word());
            end
            issue(ctrl_pkg::OP_NOP, '0, '0, '0);
        end
        read_sum();

        issue(ctrl_pkg::OP_NOP, '0, '0, '0);
        repeat (3) @(posedge clk);

        if (reads_checked != n_reads) begin
            $display("Only %0d of %0d reads returned a checked result",
                     reads_checked, n_reads);
            tb_errs = 1;
        end
        $display("Error counts: %0d value, %0d other", value_errs, other_errs + tb_errs);
        if (value_errs + other_errs + tb_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/mul_pkg.sv
rtl/ctrl_pkg.sv
rtl/approx_mul_16.sv
rtl/mac_lane.sv
rtl/op_dispatch.sv
rtl/acc_reduce.sv
rtl/dot_engine_top.sv
test/dot_checker.sv
test/tb_dot_engine.sv
